//--- build.f
verilog/tm1638_pkg.sv
verilog/panel_pkg.sv
verilog/tm1638_sio_shifter.sv
verilog/tm1638_sio_arbiter.sv
verilog/tm1638_display_writer.sv
verilog/tm1638_key_reader.sv
verilog/tm1638_board_controller.sv
verif/tm1638_chip_model.sv
verif/tb_tm1638_board_controller.sv

//--- verif/tb_tm1638_board_controller.sv
// Testbench for the TM1638 board controller
// Random panel and key stimulus, checked against a reference model and a chip model

module tb_tm1638_board_controller;

    timeunit 1ns;
    timeprecision 100ps;

    localparam clk_mhz  = 8;                 // Four clocks per sio_clk half period
    localparam w_digit  = 8;
    localparam max_wait = 20000;             // Clocks per wait

    logic               clk;
    logic               reset;
    logic [7:0]         hgfedcba;
    logic [w_digit-1:0] digit;
    logic [7:0]         ledr;
    logic [7:0]         keys;
    logic               sio_clk;
    logic               sio_stb;
    wire                sio_data;

    logic [31:0] key_scan;
    int          n_txn;
    int          txn_n_bits;
    logic [7:0]  txn_cmd;
    logic [4:0]  txn_n_bytes;
    logic [7:0]  last_data_cmd, last_addr_cmd, last_ctrl_cmd;

    integer seed = 54;
    int     n_value_err = 0;
    int     n_proto_err = 0;
    int     n_timeout   = 0;

    logic [7:0] seg_ref [w_digit];           // Segments the scan drives per digit
    logic [7:0] led_ref;
    int         scan_pos = 0;

    int   seen_txn     = 0;                  // Monitor state
    int   frames_done  = 0;
    int   polls_done   = 0;
    int   frame_step   = 0;
    int   since_frame  = 0;
    int   since_poll   = 0;
    int   stb_high_run = 0;
    logic skip_txn     = 1'b0;               // Next strobe was cut by reset

    //------------------------------------------------------------

    tm1638_board_controller # (.clk_mhz (clk_mhz), .w_digit (w_digit)) dut_i
    (
        .clk      ( clk      ),
        .reset    ( reset    ),
        .hgfedcba ( hgfedcba ),
        .digit    ( digit    ),
        .ledr     ( ledr     ),
        .keys     ( keys     ),
        .sio_clk  ( sio_clk  ),
        .sio_stb  ( sio_stb  ),
        .sio_data ( sio_data )
    );

    tm1638_chip_model chip_i
    (
        .sio_clk       ( sio_clk       ),
        .sio_stb       ( sio_stb       ),
        .sio_data      ( sio_data      ),
        .key_scan      ( key_scan      ),
        .n_txn         ( n_txn         ),
        .txn_cmd       ( txn_cmd       ),
        .txn_n_bytes   ( txn_n_bytes   ),
        .txn_n_bits    ( txn_n_bits    ),
        .last_data_cmd ( last_data_cmd ),
        .last_addr_cmd ( last_addr_cmd ),
        .last_ctrl_cmd ( last_ctrl_cmd )
    );

    always #4 clk = ~clk;                    // 8 ns period

    //------------------------------------------------------------

    task automatic compare_value (input string name, input logic [31:0] got,
                                  input logic [31:0] exp);
        assert (got === exp)
        else
        begin
            n_value_err++;
            $display ("ERR %s got 0x%0h expected 0x%0h at %0t", name, got, exp, $time);
        end
    endtask

    function automatic logic [7:0] keys_from_scan (input logic [31:0] scan);
        logic [7:0] k;
        for (int i = 0; i < 4; i++)
        begin
            k [i]     = scan [8 * i];        // Bit 0 of byte i
            k [i + 4] = scan [8 * i + 4];    // Bit 4 of byte i
        end
        return k;
    endfunction

    //------------------------------------------------------------
    // Transaction monitor

    task automatic check_transaction;
        logic [7:0] exp_cmd;
        logic [4:0] exp_len;
        compare_value ("txn_n_bits % 8", txn_n_bits % 8, 0);
        if (txn_cmd == tm1638_pkg::cmd_data_read)
        begin
            compare_value ("txn_n_bytes", txn_n_bytes, 4);
            polls_done++;
            since_poll = 0;
            since_frame++;
        end
        else
        begin
            exp_cmd = (frame_step == 0) ? tm1638_pkg::cmd_data_write
                    : (frame_step == 1) ? tm1638_pkg::cmd_addr_base
                    :                     tm1638_pkg::cmd_display_on;
            exp_len = (frame_step == 1) ? 5' (2 * w_digit) : 5'd0;
            compare_value ("txn_cmd", txn_cmd, exp_cmd);
            compare_value ("txn_n_bytes", txn_n_bytes, exp_len);
            if (frame_step == 2)
                frames_done++;               // Display on closes a frame
            frame_step  = (frame_step + 1) % 3;
            since_frame = 0;
            since_poll++;
        end
        assert (since_frame <= 2 && since_poll <= 2)
        else
        begin
            n_proto_err++;
            $display ("One client got three transactions in a row at %0t", $time);
        end
    endtask

    always @ (posedge clk)
    begin
        if (sio_stb === 1'b1)
            stb_high_run++;
        else
        begin
            if (stb_high_run > 0)
                assert (stb_high_run >= 2)
                else
                begin
                    n_proto_err++;
                    $display ("Strobe fell again right after rising at %0t", $time);
                end
            stb_high_run = 0;
        end

        if (n_txn != seen_txn)
        begin
            seen_txn = n_txn;
            if (skip_txn)
            begin
                skip_txn    = 1'b0;          // Clients restart from scratch
                frame_step  = 0;
                since_frame = 0;
                since_poll  = 0;
            end
            else
                check_transaction ();
        end
    end

    //------------------------------------------------------------
    // Stimulus

    task automatic drive_scan;
        int r;
        int a;
        @ (posedge clk);
        #1;
        r    = $random (seed);
        ledr = led_ref;
        if (r [1:0] == 2'd0)                 // Select that must not be captured
        begin
            a     = r [6:3] % w_digit;
            digit = '0;
            if (r [2])
            begin
                digit [a]                 = 1'b1;
                digit [(a + 1) % w_digit] = 1'b1;
            end
            hgfedcba = r [15:8];
        end
        else
        begin
            digit            = '0;
            digit [scan_pos] = 1'b1;
            hgfedcba         = seg_ref [scan_pos];
            scan_pos         = (scan_pos + 1) % w_digit;
        end
    endtask

    task automatic scan_until (input string what, input int frames, input int polls);
        int n;
        n = 0;
        while ((frames_done < frames || polls_done < polls) && n < max_wait)
        begin
            drive_scan ();
            n++;
        end
        assert (frames_done >= frames && polls_done >= polls)
        else
        begin
            n_timeout++;
            $display ("Timeout after %0d clocks waiting for %s", max_wait, what);
        end
    endtask

    task automatic wait_strobe_low;
        int n;
        n = 0;
        while (sio_stb !== 1'b0 && n < max_wait)
        begin
            drive_scan ();
            n++;
        end
        assert (sio_stb === 1'b0)
        else
        begin
            n_timeout++;
            $display ("Timeout after %0d clocks waiting for a strobe", max_wait);
        end
    endtask

    task automatic check_idle;
        compare_value ("sio_stb", sio_stb, 1);
        compare_value ("sio_clk", sio_clk, 1);
        compare_value ("keys", keys, 0);
    endtask

    task automatic check_display;
        for (int i = 0; i < w_digit; i++)
            seg_ref [i] = $random (seed);
        led_ref = $random (seed);
        scan_until ("two display frames", frames_done + 2, 0);
        for (int i = 0; i < w_digit; i++)
        begin
            compare_value ($sformatf ("ram[%0d]", 2 * i), chip_i.ram [2 * i], seg_ref [i]);
            compare_value ($sformatf ("ram[%0d][0]", 2 * i + 1),
                           chip_i.ram [2 * i + 1][0], led_ref [i]);
        end
    endtask

    task automatic check_keys;
        key_scan = $random (seed);           // Unused bits random as well
        scan_until ("two key polls", 0, polls_done + 2);
        compare_value ("keys", keys, keys_from_scan (key_scan));
    endtask

    task automatic reset_mid_transaction;
        int delay;
        wait_strobe_low ();
        delay = $random (seed) & 15;
        repeat (delay)
            drive_scan ();
        skip_txn = 1'b1;
        reset    = 1'b1;
        drive_scan ();
        compare_value ("sio_stb", sio_stb, 1);   // One clock into reset
        repeat (7)
            drive_scan ();
        check_idle ();
        reset = 1'b0;
    endtask

    //------------------------------------------------------------

    initial
    begin
        clk      = 1'b0;
        reset    = 1'b1;
        hgfedcba = 8'h00;
        digit    = '0;
        ledr     = 8'h00;
        key_scan = 32'h0;
        led_ref  = 8'h00;
        for (int i = 0; i < w_digit; i++)
            seg_ref [i] = 8'h00;

        repeat (8)
            @ (posedge clk);
        #1;
        check_idle ();
        compare_value ("n_txn", n_txn, 0);   // Nothing sent during reset
        reset = 1'b0;

        for (int round = 0; round < 2; round++)
        begin
            check_display ();
            check_keys ();
        end

        reset_mid_transaction ();
        check_display ();
        check_keys ();

        compare_value ("last_data_cmd", last_data_cmd, tm1638_pkg::cmd_data_read);
        compare_value ("last_addr_cmd", last_addr_cmd, tm1638_pkg::cmd_addr_base);
        compare_value ("last_ctrl_cmd", last_ctrl_cmd, tm1638_pkg::cmd_display_on);

        $display ("Errors: %0d value, %0d protocol, %0d timeout",
                  n_value_err, n_proto_err, n_timeout);
        if (n_value_err + n_proto_err + n_timeout == 0)
            $display ("Regression passed");
        else
            $display ("Regression failed");
        $finish;
    end

endmodule

//--- verif/tm1638_chip_model.sv
// Behavioral TM1638 for simulation
// Decodes strobed transactions, keeps display RAM and answers key scan reads

module tm1638_chip_model
(
    input  logic        sio_clk,
    input  logic        sio_stb,
    inout  wire         sio_data,

    input  logic [31:0] key_scan,        // Key bytes, byte 0 in bits 7:0

    output int          n_txn,           // Completed strobes
    output logic [7:0]  txn_cmd,         // First byte of the last strobe
    output logic [4:0]  txn_n_bytes,     // Whole bytes after the first
    output int          txn_n_bits,      // All bits of the last strobe
    output logic [7:0]  last_data_cmd,
    output logic [7:0]  last_addr_cmd,
    output logic [7:0]  last_ctrl_cmd
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [7:0] ram [16];                // Display RAM
    logic [7:0] rx_byte;
    logic [7:0] cmd;
    logic [3:0] addr;
    logic       in_txn;                  // Strobe seen falling
    logic       reading;                 // Chip owns sio_data
    logic       drive_en;
    logic       drive_bit;
    int         n_bits;
    int         idx;

    assign sio_data = drive_en ? drive_bit : 1'bz;

    initial
    begin
        for (int i = 0; i < 16; i++)
            ram [i] = 8'h00;
        n_txn         = 0;
        txn_cmd       = 8'h00;
        txn_n_bytes   = 5'd0;
        txn_n_bits    = 0;
        last_data_cmd = 8'h00;
        last_addr_cmd = 8'h00;
        last_ctrl_cmd = 8'h00;
        in_txn        = 1'b0;
        reading       = 1'b0;
        drive_en      = 1'b0;
        drive_bit     = 1'b0;
        n_bits        = 0;
    end

    //------------------------------------------------------------
    // Byte decode

    task automatic take_byte;
        if (n_bits == 8)
        begin
            cmd = rx_byte;
            case (rx_byte [7:6])
            2'b01:
            begin
                last_data_cmd = rx_byte;
                reading       = rx_byte [1];     // Key read follows
            end
            2'b11:
            begin
                last_addr_cmd = rx_byte;
                addr          = rx_byte [3:0];
            end
            2'b10:
                last_ctrl_cmd = rx_byte;
            default:
                ;                                // Not a TM1638 command
            endcase
        end
        else if (cmd [7:6] == 2'b11)
        begin
            ram [addr] = rx_byte;
            addr       = addr + 1'b1;            // Auto increment
        end
    endtask

    //------------------------------------------------------------
    // Wire side

    always @ (negedge sio_stb)
    begin
        in_txn  = 1'b1;
        reading = 1'b0;
        n_bits  = 0;
    end

    always @ (posedge sio_clk)
        if (in_txn)
        begin
            n_bits = n_bits + 1;
            if (!reading)
            begin
                rx_byte = {sio_data, rx_byte [7:1]};   // LSB first
                if (n_bits % 8 == 0)
                    take_byte ();
            end
        end

    always @ (negedge sio_clk)
        if (in_txn && reading)
        begin
            idx       = n_bits - 8;              // Read bits already clocked
            drive_en  = 1'b1;
            drive_bit = (idx < 32) ? key_scan [idx] : 1'b0;
        end

    always @ (posedge sio_stb)
        if (in_txn)                              // Skips the rise out of X
        begin
            in_txn      = 1'b0;
            drive_en    = 1'b0;
            txn_cmd     = cmd;
            txn_n_bits  = n_bits;
            txn_n_bytes = (n_bits >= 8) ? 5' (n_bits / 8 - 1) : 5'd0;
            n_txn       = n_txn + 1;
        end

endmodule

//--- verilog/panel_pkg.sv
// Board-side panel definitions
// Frame-buffer entries and the key scan byte layout

package panel_pkg;

    //----------------------------------------------------------
    // One digit of the frame buffer

    typedef struct packed {
        logic       led;         // Red LED under the digit
        logic [7:0] hgfedcba;    // Segment bits, a in bit 0
    } digit_entry_t;

    //----------------------------------------------------------
    // One key scan byte as read back from the chip

    typedef struct packed {
        logic [2:0] unused_hi;
        logic       key_high;    // Key i + 4
        logic [2:0] unused_lo;
        logic       key_low;     // Key i
    } key_byte_t;

endpackage

//--- verilog/tm1638_board_controller.sv
// TM1638 LED-and-key board controller
// Display writer and key reader share the serial link through an arbiter

module tm1638_board_controller
# (
    parameter clk_mhz = 50,
              w_digit = 8
)
(
    input  logic                 clk,
    input  logic                 reset,

    input  logic [7:0]           hgfedcba,
    input  logic [w_digit - 1:0] digit,
    input  logic [7:0]           ledr,
    output logic [7:0]           keys,

    output logic                 sio_clk,
    output logic                 sio_stb,
    inout  wire                  sio_data
);

    //----------------------------------------------------------

    logic                     disp_req, disp_ack, key_req, key_ack;
    tm1638_pkg::sio_request_t disp_request, key_request, sio_request;
    tm1638_pkg::sio_byte_t    disp_fetch_byte, fetch_byte, rd_byte;
    logic                     sio_req, sio_ack;
    logic [3:0]               fetch_index;
    logic                     rd_valid, key_rd_valid;
    logic [1:0]               rd_index;

    //----------------------------------------------------------

    tm1638_display_writer # (.w_digit (w_digit)) i_writer
    (
        .clk         ( clk             ),
        .reset       ( reset           ),
        .hgfedcba    ( hgfedcba        ),
        .digit       ( digit           ),
        .ledr        ( ledr            ),
        .req         ( disp_req        ),
        .request     ( disp_request    ),
        .ack         ( disp_ack        ),
        .fetch_index ( fetch_index     ),
        .fetch_byte  ( disp_fetch_byte )
    );

    tm1638_key_reader i_reader
    (
        .clk      ( clk          ),
        .reset    ( reset        ),
        .req      ( key_req      ),
        .request  ( key_request  ),
        .ack      ( key_ack      ),
        .rd_valid ( key_rd_valid ),
        .rd_index ( rd_index     ),   // Straight from the shifter
        .rd_byte  ( rd_byte      ),
        .keys     ( keys         )
    );

    tm1638_sio_arbiter i_arbiter
    (
        .clk             ( clk             ),
        .reset           ( reset           ),
        .disp_req        ( disp_req        ),
        .key_req         ( key_req         ),
        .disp_request    ( disp_request    ),
        .key_request     ( key_request     ),
        .disp_ack        ( disp_ack        ),
        .key_ack         ( key_ack         ),
        .sio_req         ( sio_req         ),
        .sio_request     ( sio_request     ),
        .sio_ack         ( sio_ack         ),
        .disp_fetch_byte ( disp_fetch_byte ),
        .fetch_byte      ( fetch_byte      ),
        .rd_valid        ( rd_valid        ),
        .key_rd_valid    ( key_rd_valid    )
    );

    tm1638_sio_shifter # (.clk_mhz (clk_mhz)) i_shifter
    (
        .clk         ( clk         ),
        .reset       ( reset       ),
        .req         ( sio_req     ),
        .request     ( sio_request ),
        .ack         ( sio_ack     ),
        .fetch_index ( fetch_index ),
        .fetch_byte  ( fetch_byte  ),
        .rd_valid    ( rd_valid    ),
        .rd_index    ( rd_index    ),
        .rd_byte     ( rd_byte     ),
        .sio_clk     ( sio_clk     ),
        .sio_stb     ( sio_stb     ),
        .sio_data    ( sio_data    )   // Shared with the chip
    );

endmodule

//--- verilog/tm1638_display_writer.sv
// TM1638 display writer
// Captures multiplexed segments and LEDs into a frame buffer and refreshes the chip

module tm1638_display_writer
# (
    parameter w_digit = 8
)
(
    input  logic                     clk,
    input  logic                     reset,

    input  logic [7:0]               hgfedcba,
    input  logic [w_digit - 1:0]     digit,
    input  logic [7:0]               ledr,

    output logic                     req,
    output tm1638_pkg::sio_request_t request,
    input  logic                     ack,

    input  logic [3:0]               fetch_index,
    output tm1638_pkg::sio_byte_t    fetch_byte
);

    //----------------------------------------------------------

    localparam logic [4:0] n_frame_bytes = 5' (2 * w_digit);  // Segments and LED per digit

    localparam logic [1:0] step_mode = 2'd0,   // Data write command
                           step_data = 2'd1,   // Address command and frame
                           step_show = 2'd2;   // Display on

    panel_pkg::digit_entry_t frame [w_digit];
    panel_pkg::digit_entry_t fetch_entry;
    logic [1:0]              step;

    //----------------------------------------------------------
    // Frame capture

    always_ff @ (posedge clk)
        if (reset)
        begin
            for (int i = 0; i < w_digit; i++)
                frame [i] <= '0;                  // Blank panel
        end
        else
        begin
            for (int i = 0; i < w_digit; i++)
            begin
                if ($onehot (digit) && digit [i])
                    frame [i].hgfedcba <= hgfedcba;
                frame [i].led <= ledr [i];        // LEDs are static levels
            end
        end

    //----------------------------------------------------------
    // Frame sequencer

    always_ff @ (posedge clk)
        if (reset)
        begin
            req  <= 1'b0;
            step <= step_mode;
        end
        else if (!req && !ack)
            req <= 1'b1;
        else if (req && ack)
        begin
            req  <= 1'b0;
            step <= (step == step_show) ? step_mode : step + 1'b1;
        end

    always_comb
    begin
        request.n_bytes = 5'd0;
        case (step)
        step_mode:
            request.cmd.raw = tm1638_pkg::cmd_data_write;
        step_data:
        begin
            request.cmd.raw = tm1638_pkg::cmd_addr_base;
            request.n_bytes = n_frame_bytes;
        end
        default:
            request.cmd.raw = tm1638_pkg::cmd_display_on;
        endcase
    end

    //----------------------------------------------------------
    // Byte fetch, even index segments, odd index LED

    assign fetch_entry = frame [fetch_index [3:1]];
    assign fetch_byte  = fetch_index [0] ? {7'd0, fetch_entry.led} : fetch_entry.hgfedcba;

endmodule

//--- verilog/tm1638_key_reader.sv
// TM1638 key reader
// Polls the four key scan bytes and maps them to eight key levels

module tm1638_key_reader
(
    input  logic                     clk,
    input  logic                     reset,

    output logic                     req,
    output tm1638_pkg::sio_request_t request,
    input  logic                     ack,

    input  logic                     rd_valid,
    input  logic [1:0]               rd_index,
    input  tm1638_pkg::sio_byte_t    rd_byte,

    output logic [7:0]               keys
);

    panel_pkg::key_byte_t shadow [3];   // Bytes 0 to 2 of the poll
    panel_pkg::key_byte_t last_byte;

    assign request.cmd.raw = tm1638_pkg::cmd_data_read;
    assign request.n_bytes = 5'd4;
    assign last_byte       = rd_byte;

    //----------------------------------------------------------

    always_ff @ (posedge clk)
        if (reset)
            req <= 1'b0;
        else if (!req && !ack)
            req <= 1'b1;                    // Poll again
        else if (req && ack)
            req <= 1'b0;

    always_ff @ (posedge clk)
        if (reset)
            keys <= 8'd0;
        else if (rd_valid)
        begin
            if (rd_index != 2'd3)
                shadow [rd_index] <= rd_byte;
            else
                keys <= {last_byte.key_high,  // Keys 4 to 7 from bit 4
                         shadow [2].key_high,
                         shadow [1].key_high,
                         shadow [0].key_high,
                         last_byte.key_low,   // Keys 0 to 3 from bit 0
                         shadow [2].key_low,
                         shadow [1].key_low,
                         shadow [0].key_low};
        end

endmodule

//--- verilog/tm1638_pkg.sv
// TM1638 wire protocol definitions
// Command encodings, command-byte views and the serial request bundle

package tm1638_pkg;

    //----------------------------------------------------------
    // Data word on the serial link

    typedef logic [7:0] sio_byte_t;

    //----------------------------------------------------------
    // Command bytes

    localparam sio_byte_t cmd_data_write = 8'h40;   // Auto increment, write
    localparam sio_byte_t cmd_data_read  = 8'h42;   // Read key scan bytes
    localparam sio_byte_t cmd_addr_base  = 8'hC0;   // Address 0
    localparam sio_byte_t cmd_display_on = 8'h8F;   // Display on, full brightness

    localparam logic [1:0] kind_data = 2'b01;       // Top two bits of a data command
    localparam logic [1:0] kind_addr = 2'b11;       // Top two bits of an address command

    //----------------------------------------------------------
    // Two views of the first byte of a transaction

    typedef struct packed {
        logic [1:0] kind;        // 2'b01
        logic [1:0] unused_hi;
        logic       test_mode;
        logic       fixed_addr;  // 0 = auto increment
        logic       read;        // 1 = key read
        logic       unused_lo;
    } data_cmd_t;

    typedef struct packed {
        logic [1:0] kind;        // 2'b11
        logic [1:0] unused;
        logic [3:0] addr;        // First display RAM address
    } addr_cmd_t;

    typedef union packed {
        data_cmd_t data_cmd;
        addr_cmd_t addr_cmd;
        sio_byte_t raw;          // As sent on the wire
    } cmd_byte_u;

    //----------------------------------------------------------
    // One strobed transaction

    typedef struct packed {
        cmd_byte_u  cmd;         // Byte sent first
        logic [4:0] n_bytes;     // Following bytes, 0 to 16
    } sio_request_t;

endpackage

//--- verilog/tm1638_sio_arbiter.sv
// Round-robin arbiter for the TM1638 serial link
// Passes one client's four-phase request to the shifter at a time

module tm1638_sio_arbiter
(
    input  logic                     clk,
    input  logic                     reset,

    input  logic                     disp_req,
    input  logic                     key_req,
    input  tm1638_pkg::sio_request_t disp_request,
    input  tm1638_pkg::sio_request_t key_request,
    output logic                     disp_ack,
    output logic                     key_ack,

    output logic                     sio_req,
    output tm1638_pkg::sio_request_t sio_request,
    input  logic                     sio_ack,

    input  tm1638_pkg::sio_byte_t    disp_fetch_byte,
    output tm1638_pkg::sio_byte_t    fetch_byte,

    input  logic                     rd_valid,
    output logic                     key_rd_valid
);

    logic grant_key;      // Owner, 1 = key reader
    logic grant_valid;    // Owner holds the link
    logic owner_req;

    assign owner_req    = grant_key ? key_req : disp_req;
    assign sio_req      = grant_valid && owner_req;
    assign sio_request  = grant_key ? key_request : disp_request;
    assign disp_ack     = grant_valid && !grant_key && sio_ack;
    assign key_ack      = grant_valid &&  grant_key && sio_ack;
    assign fetch_byte   = grant_key ? '0 : disp_fetch_byte;  // Only the writer sends data
    assign key_rd_valid = grant_valid && grant_key && rd_valid;

    always_ff @ (posedge clk)
        if (reset)
        begin
            grant_valid <= 1'b0;
            grant_key   <= 1'b0;
        end
        else if (!grant_valid)
        begin
            if (!sio_ack && (disp_req || key_req))  // Handshake fully idle
            begin
                grant_valid <= 1'b1;
                grant_key   <= (disp_req && key_req) ? !grant_key : key_req;
            end
        end
        else if (sio_ack && !owner_req)
            grant_valid <= 1'b0;                    // Owner finished its handshake

    //----------------------------------------------------------

    a_one_owner : assert property (@ (posedge clk) disable iff (reset)
        sio_ack |-> $onehot ({disp_ack, key_ack}));

endmodule

//--- verilog/tm1638_sio_shifter.sv
// TM1638 serial engine
// Runs one strobed transaction, LSB first, writing or reading the data bytes

module tm1638_sio_shifter
# (
    parameter clk_mhz = 50
)
(
    input  logic                     clk,
    input  logic                     reset,

    input  logic                     req,
    input  tm1638_pkg::sio_request_t request,
    output logic                     ack,

    output logic [3:0]               fetch_index,
    input  tm1638_pkg::sio_byte_t    fetch_byte,

    output logic                     rd_valid,
    output logic [1:0]               rd_index,
    output tm1638_pkg::sio_byte_t    rd_byte,

    output logic                     sio_clk,
    output logic                     sio_stb,
    inout  logic                     sio_data
);

    //----------------------------------------------------------

    localparam half_clks = (clk_mhz / 2 > 0) ? clk_mhz / 2 : 1;  // About 1 MHz on sio_clk
    localparam w_div     = $clog2 (half_clks + 1);

    localparam logic [w_div - 1:0] div_reload = w_div' (half_clks - 1);

    localparam logic [2:0] s_idle = 3'd0,
                           s_lead = 3'd1,   // Strobe low before first bit
                           s_low  = 3'd2,
                           s_high = 3'd3,
                           s_tail = 3'd4,   // Half period after last bit
                           s_done = 3'd5;   // Ack high until req drops

    logic [2:0]               state;
    logic [w_div - 1:0]       div_cnt;
    logic [2:0]               bit_cnt;
    logic [4:0]               byte_num;     // 0 is the command byte
    tm1638_pkg::sio_request_t cur;
    tm1638_pkg::sio_byte_t    shift_reg;

    logic div_done, is_read, is_addr, rx_phase, last_bit, last_byte;

    assign div_done  = div_cnt == '0;
    assign is_read   = cur.cmd.data_cmd.kind == tm1638_pkg::kind_data
                       && cur.cmd.data_cmd.read;
    assign is_addr   = cur.cmd.addr_cmd.kind == tm1638_pkg::kind_addr;
    assign rx_phase  = is_read && byte_num != 5'd0;  // Chip owns sio_data
    assign last_bit  = bit_cnt == 3'd7;
    assign last_byte = byte_num == cur.n_bytes;

    assign fetch_index = (is_addr ? cur.cmd.addr_cmd.addr : 4'd0) + byte_num [3:0];
    assign rd_valid    = state == s_high && div_done && last_bit && rx_phase;
    assign rd_index    = byte_num [1:0] - 2'd1;
    assign rd_byte     = shift_reg;

    assign sio_data = (state != s_idle && state != s_done && !rx_phase)
                      ? shift_reg [0] : 1'bz;   // Released when idle or reading

    //----------------------------------------------------------

    always_ff @ (posedge clk)
        if (reset)
        begin
            state    <= s_idle;
            sio_stb  <= 1'b1;
            sio_clk  <= 1'b1;
            ack      <= 1'b0;
            div_cnt  <= '0;
            bit_cnt  <= 3'd0;
            byte_num <= 5'd0;
        end
        else
        begin
            if (state != s_idle && !div_done)
                div_cnt <= div_cnt - 1'b1;

            case (state)
            s_idle:
                if (req)
                begin
                    cur       <= request;
                    shift_reg <= request.cmd.raw;
                    sio_stb   <= 1'b0;                  // Strobe falls first
                    div_cnt   <= div_reload;
                    bit_cnt   <= 3'd0;
                    byte_num  <= 5'd0;
                    state     <= s_lead;
                end
            s_lead:
                if (div_done)
                begin
                    sio_clk <= 1'b0;
                    div_cnt <= div_reload;
                    state   <= s_low;
                end
            s_low:
                if (div_done)
                begin
                    sio_clk <= 1'b1;                    // Rising edge, both sides sample
                    if (rx_phase)
                        shift_reg <= {sio_data, shift_reg [7:1]};
                    div_cnt <= div_reload;
                    state   <= s_high;
                end
            s_high:
                if (div_done)
                begin
                    div_cnt <= div_reload;
                    if (!last_bit)
                    begin
                        sio_clk <= 1'b0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (!rx_phase)
                            shift_reg <= shift_reg >> 1;  // Next bit while clock low
                        state <= s_low;
                    end
                    else if (last_byte)
                        state <= s_tail;
                    else
                    begin
                        sio_clk  <= 1'b0;
                        bit_cnt  <= 3'd0;
                        byte_num <= byte_num + 1'b1;
                        if (!is_read)
                            shift_reg <= fetch_byte;      // Newest client data
                        state <= s_low;
                    end
                end
            s_tail:
                if (div_done)
                begin
                    sio_stb <= 1'b1;
                    ack     <= 1'b1;
                    state   <= s_done;
                end
            default:
                if (!req)
                begin
                    ack   <= 1'b0;
                    state <= s_idle;
                end
            endcase
        end

    //----------------------------------------------------------

    a_idle_stb : assert property (@ (posedge clk) disable iff (reset)
        state == s_idle |-> sio_stb);

    a_req_held : assert property (@ (posedge clk) disable iff (reset)
        (state != s_idle && !ack) |-> req);

endmodule
